/* dv/obj_asserts.sv */
`default_nettype none

module obj_asserts (
    input wire logic                clk,
    input wire logic                rst,
    input wire logic                dr_start,
    input wire logic                dr_idle,
    input wire logic                rom_cs,
    input wire logic                rom_ok,
    input wire logic                buf_we,
    input obj_pkg::obj_pixel_t      buf_pix
);
    timeunit 1ns;
    timeprecision 100ps;

    // scanner only starts a free engine
    a_start_idle: assert property (@(posedge clk) disable iff (rst) dr_start |-> dr_idle)
        else $error("dr_start while draw engine busy");

    a_idle_fall: assert property (@(posedge clk) disable iff (rst) dr_start |=> !dr_idle)
        else $error("dr_idle did not fall after dr_start");

    // request held until the rom answers
    a_cs_hold: assert property (@(posedge clk) disable iff (rst) rom_cs && !rom_ok |=> rom_cs)
        else $error("rom_cs dropped before rom_ok");

    a_no_clear_write: assert property (@(posedge clk) disable iff (rst)
        buf_we |-> buf_pix.color != 4'd0)
        else $error("transparent pixel written to line buffer");

endmodule

bind obj_draw obj_asserts u_asserts (
    .clk      (clk),
    .rst      (rst),
    .dr_start (dr_start),
    .dr_idle  (dr_idle),
    .rom_cs   (rom_cs),
    .rom_ok   (rom_ok),
    .buf_we   (buf_we),
    .buf_pix  (buf_pix)
);

`default_nettype wire

/* dv/obj_clk_gen.sv */
`default_nettype none

module obj_clk_gen #(
    parameter real period = 8.0
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;
    always #(period / 2.0) clk = ~clk;   // free running

endmodule

`default_nettype wire

/* dv/obj_tb.sv */
`default_nettype none

module obj_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int lines_per = 6;
    localparam int n_lines   = 7 * (lines_per + 1) + 2;   // seven phases with a setup line each

    logic clk, rst, cfg_we, tbl_we, rom_ok, rom_cs;
    logic [1:0] cfg_sel;
    logic [9:0] cfg_data;
    logic [7:0] tbl_addr;
    logic [8:0] vrender, hdump, hd, vr;
    logic [63:0] rom_data;
    logic [19:0] rom_addr, req_addr;
    obj_pkg::obj_entry_t tbl_data;
    obj_pkg::obj_pixel_t pix;

    // model state
    obj_pkg::obj_entry_t tbl_m [16];
    obj_pkg::obj_cfg_t   mcfg;
    obj_pkg::obj_pixel_t exp_show [512];   // half being read out now
    obj_pkg::obj_pixel_t exp_draw [512];   // half the scan is filling
    logic [63:0] rom_mem [logic [19:0]];
    logic [19:0] exp_fetch [$];
    integer seed = 55;
    string  test_name = "reset";
    int     rom_lat_max = 6;
    int     lat;
    logic   busy;

    obj_clk_gen #(.period(8.0)) u_clk (.clk(clk));

    obj_top #(.table_aw(8), .line_w(512)) DUT (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_sel(cfg_sel), .cfg_data(cfg_data),
        .tbl_we(tbl_we), .tbl_addr(tbl_addr), .tbl_data(tbl_data),
        .vrender(vrender), .hdump(hdump), .rom_ok(rom_ok), .rom_data(rom_data),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .pix(pix)
    );

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pixel(string name, obj_pkg::obj_pixel_t exp, obj_pkg::obj_pixel_t act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s pixel %0d: expected %h actual %h",
                               name, hd, exp, act));
    endtask

    task automatic check_rom_addr(string name, logic [19:0] exp, logic [19:0] act);
        if (act !== exp)
            fail_run($sformatf("MISMATCH %s rom_addr: expected %h actual %h", name, exp, act));
    endtask

    function automatic int rand_below(int range);
        return ($random(seed) & 32'h7fff_ffff) % range;
    endfunction

    // rom contents made up on first touch
    function automatic logic [63:0] rom_word(logic [19:0] a);
        if (!rom_mem.exists(a))
            rom_mem[a] = {$random(seed), $random(seed)};
        return rom_mem[a];
    endfunction

    // expected image and fetch order for one scan
    task automatic render_line();
        obj_pkg::obj_entry_t e;
        logic [8:0] vf, hp;
        logic [9:0] ox, oy, ydiff, ex, xp;
        logic [3:0] tm, tn, m, row, vs, npos, c, off;
        logic [19:0] a;
        logic [63:0] d;
        logic stop;
        stop = 1'b0;
        vf = vr ^ {1'b0, {8{mcfg.flip}}};   // flip only mirrors the line number
        for (int x = 0; x < 512; x++)
            exp_draw[x] = '0;
        for (int i = 0; i < 16 && !stop; i++) begin
            e = tbl_m[i];
            stop = e.y[15] || (e.attr[15:8] == 8'hff);
            ox = e.x[9:0] + 10'h40 - (e.attr[7] ? 10'd0 : mcfg.off_x);
            oy = e.y[9:0] + 10'h10 - (e.attr[7] ? 10'd0 : mcfg.off_y);
            ydiff = {1'b0, vf} - oy;
            tm = e.attr[15:12];
            tn = e.attr[11:8];
            if (!stop && int'(ydiff) < (int'(tm) + 1) * 16) begin
                m   = ydiff[7:4];
                row = e.attr[6] ? tm - m : m;
                vs  = ydiff[3:0] ^ {4{e.attr[6]}};
                for (int n = 0; n <= int'(tn); n++) begin
                    npos = e.attr[5] ? tn - 4'(n) : 4'(n);
                    ex   = ox + {2'b00, npos, 4'd0};
                    if (!ex[9]) begin              // left of screen so no fetch
                        a = {e.code + 16'(n) + {8'd0, row, 4'd0}, vs};
                        exp_fetch.push_back(a);
                        d  = rom_word(a);
                        hp = ex[8:0] - 9'd1;
                        for (int k = 0; k < 16; k++) begin
                            c   = d[k*4 +: 4];
                            off = e.attr[5] ? 4'(15 - k) : 4'(k);
                            xp  = {1'b0, hp} + {6'd0, off};
                            if (c != 0 && xp < 512 && exp_draw[xp].color == 0)
                                exp_draw[xp] = '{pal: e.attr[4:0], color: c, prio: e.x[15:13]};
                        end
                    end
                end
            end
        end
    endtask

    // one clock of output check and counter advance
    task automatic step();
        @(posedge clk);
        #1;
        check_pixel(test_name, exp_show[hd], pix);
        if (hd == obj_pkg::start_hpos) begin
            if (exp_fetch.size() != 0)
                fail_run("previous scan did not fetch every expected tile row");
            exp_show = exp_draw;
            render_line();
        end
        hd = hd + 9'd1;
        if (hd == 9'd0)
            vr = vr + 9'd1;
        hdump   = hd;
        vrender = vr;
    endtask

    // kind 0 single 1 multi 2 scroll 3 end 4 stall 5 overlap 6 empty
    task automatic gen_table(int kind);
        logic [8:0] vfb;
        logic [9:0] yp, xp;
        logic [3:0] tm, tn;
        logic b7;
        int cnt;
        cnt = (kind == 6) ? 0 : (kind == 4 ? 4 : 6);
        mcfg = '0;
        if (kind == 2)
            mcfg = '{off_x: 10'(rand_below(256)), off_y: 10'(rand_below(64)),
                     flip: 1'(rand_below(2))};
        vr  = 9'(rand_below(200) + 20);
        vfb = vr ^ {1'b0, {8{mcfg.flip}}};
        for (int i = 0; i < 16; i++) begin
            tm = (kind == 1 || kind == 2) ? 4'(rand_below(4)) : 4'd0;
            // stall objects are two columns wide so the second tile waits
            tn = (kind == 1 || kind == 5) ? 4'(rand_below(2)) : (kind == 4 ? 4'd1 : 4'd0);
            b7 = (kind == 2) ? 1'(rand_below(2)) : 1'b0;
            yp = {1'b0, vfb} - 10'(rand_below(kind == 4 ? 16 : 48)) - 10'h10
                 + (b7 ? 10'd0 : mcfg.off_y);     // stall objects all on the first line
            xp = (kind == 5) ? 10'(100 + rand_below(24)) : 10'(rand_below(512));
            tbl_m[i] = '{x: {3'(rand_below(8)), 3'b000, xp},
                         y: {1'b0, 2'(rand_below(4)), 3'b000, yp},
                         code: 16'($random(seed)),
                         attr: {tm, tn, b7, 2'(rand_below(4)), 5'(rand_below(32))}};
            if (i == cnt) begin
                if (kind == 3 && rand_below(2) == 1)
                    tbl_m[i].attr[15:8] = 8'hff;    // all-ones size ends it too
                else
                    tbl_m[i].y[15] = 1'b1;
            end
        end
    endtask

    task automatic run_phase(string name, int kind, int lat_max);
        while (hd != 9'd440)
            step();                                // host writes after the scan ends
        test_name = name;
        gen_table(kind);
        for (int i = 0; i < 16; i++) begin
            tbl_we   = 1'b1;
            tbl_addr = 8'(i);
            tbl_data = tbl_m[i];
            step();
        end
        tbl_we  = 1'b0;
        cfg_we  = 1'b1;
        cfg_sel = 2'd0;
        cfg_data = mcfg.off_x;
        step();
        cfg_sel  = 2'd1;
        cfg_data = mcfg.off_y;
        step();
        cfg_sel  = 2'd2;
        cfg_data = {9'd0, mcfg.flip};
        step();
        cfg_we = 1'b0;
        rom_lat_max = lat_max;
        repeat (lines_per * 512) step();
    endtask

    // rom model with variable latency and one request at a time
    initial begin
        rom_ok   = 1'b0;
        rom_data = '0;
        busy     = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (rom_ok) begin
                rom_ok = 1'b0;
                busy   = 1'b0;
            end else if (busy) begin
                lat = lat - 1;
                if (lat == 0) begin
                    rom_ok   = 1'b1;
                    rom_data = rom_word(req_addr);
                end
            end else if (rom_cs && !rst) begin
                req_addr = rom_addr;
                if (exp_fetch.size() == 0) begin
                    fail_run("ROM fetch with no tile row expected");
                end else begin
                    check_rom_addr(test_name, exp_fetch.pop_front(), rom_addr);
                    busy = 1'b1;
                    lat  = 1 + rand_below(rom_lat_max);
                end
            end
        end
    end

    initial begin
        repeat (n_lines * 512 + 1000) @(posedge clk);
        fail_run("timeout: testbench did not reach the end of its tests");
    end

    initial begin
        rst = 1'b1;
        cfg_we = 1'b0;
        cfg_sel = '0;
        cfg_data = '0;
        tbl_we = 1'b0;
        tbl_addr = '0;
        tbl_data = '0;
        hd = '0;
        vr = '0;
        hdump = '0;
        vrender = '0;
        mcfg = '0;
        for (int x = 0; x < 512; x++) begin
            exp_show[x] = '0;
            exp_draw[x] = '0;
        end
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
        run_phase("single", 0, 6);
        run_phase("multi", 1, 6);
        run_phase("scroll", 2, 6);
        run_phase("table_end", 3, 6);
        run_phase("back_pressure", 4, 30);
        run_phase("overlap", 5, 6);
        run_phase("clear", 6, 6);                  // leftovers must read transparent
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
hw/obj_pkg.sv
hw/obj_cfg_regs.sv
hw/obj_table.sv
hw/obj_tile_match.sv
hw/obj_scan.sv
hw/obj_draw.sv
hw/obj_line_buf.sv
hw/obj_top.sv
dv/obj_clk_gen.sv
dv/obj_asserts.sv
dv/obj_tb.sv

/* hw/obj_cfg_regs.sv */
`default_nettype none

module obj_cfg_regs (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cfg_we,
    input  wire logic [1:0]       cfg_sel,
    input  wire logic [9:0]       cfg_data,
    output obj_pkg::obj_cfg_t     cfg
);

    // host write decode, one register per select value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg <= '0;
        end else if (cfg_we) begin
            case (cfg_sel)
                2'd0: cfg.off_x <= cfg_data;    // horizontal scroll
                2'd1: cfg.off_y <= cfg_data;    // vertical scroll
                2'd2: cfg.flip  <= cfg_data[0];
                default: ;                       // select 3 not mapped
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/obj_draw.sv */
`default_nettype none

module obj_draw #(
    parameter int line_w = 512
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          dr_start,
    input  obj_pkg::obj_cmd_t                  cmd,
    input  wire logic                          rom_ok,
    input  wire logic [obj_pkg::rom_dw-1:0]    rom_data,
    output logic                               dr_idle,
    output logic                               rom_cs,
    output logic [obj_pkg::rom_aw-1:0]         rom_addr,
    output logic                               buf_we,
    output logic [8:0]                         buf_addr,
    output obj_pkg::obj_pixel_t                buf_pix
);

    obj_pkg::obj_cmd_t cmd_q;

    logic [obj_pkg::rom_dw-1:0] row_ord;   // rom row in screen order
    logic [obj_pkg::rom_dw-1:0] row_q;
    logic                       drawing;
    logic [3:0]                 cnt;       // pixel offset in the row
    logic [3:0]                 cur;
    logic [9:0]                 x_pos;

    // address held steady for the whole request
    assign rom_addr = {cmd_q.code, cmd_q.vsub};

    // nibble k lands at offset k, mirrored under hflip
    always_comb begin
        for (int k = 0; k < 16; k++)
            row_ord[(cmd_q.hflip ? 15 - k : k) * 4 +: 4] = rom_data[k * 4 +: 4];
    end

    assign cur   = row_q[{cnt, 2'b00} +: 4];
    assign x_pos = {1'b0, cmd_q.hpos} + {6'd0, cnt};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dr_idle <= 1'b1;
            rom_cs  <= 1'b0;
            drawing <= 1'b0;
            cnt     <= 4'd0;
            buf_we  <= 1'b0;
        end else begin
            // skip transparent pixels and anything past the line end
            buf_we <= drawing && (cur != 4'd0) && (x_pos < line_w);
            if (dr_start) begin
                dr_idle <= 1'b0;
                rom_cs  <= 1'b1;
            end
            if (rom_cs && rom_ok) begin
                rom_cs  <= 1'b0;
                drawing <= 1'b1;
                cnt     <= 4'd0;
            end
            if (drawing) begin
                cnt <= cnt + 4'd1;
                if (cnt == 4'd15) begin
                    drawing <= 1'b0;
                    dr_idle <= 1'b1;    // last pixel goes out this cycle
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start)
            cmd_q <= cmd;
        if (rom_cs && rom_ok)
            row_q <= row_ord;
        buf_addr <= x_pos[8:0];
        buf_pix  <= '{pal: cmd_q.pal, color: cur, prio: cmd_q.prio};
    end

endmodule

`default_nettype wire

/* hw/obj_line_buf.sv */
`default_nettype none

module obj_line_buf #(
    parameter int line_w = 512
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          line,      // half being drawn
    input  wire logic [8:0]    hdump,
    input  wire logic          buf_we,
    input  wire logic [8:0]    buf_addr,
    input  obj_pkg::obj_pixel_t buf_pix,
    output obj_pkg::obj_pixel_t pix
);

    obj_pkg::obj_pixel_t mem [2][line_w];

    logic rd_half;
    logic free;      // target still transparent

    assign rd_half = ~line;
    assign free    = mem[line][buf_addr].color == 4'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix <= '0;
            // both halves start out transparent
            for (int i = 0; i < line_w; i++) begin
                mem[0][i] <= '0;
                mem[1][i] <= '0;
            end
        end else begin
            // first writer keeps the pixel
            if (buf_we && free)
                mem[line][buf_addr] <= buf_pix;
            if (hdump < line_w) begin
                pix                <= mem[rd_half][hdump];
                mem[rd_half][hdump] <= '0;    // ready for reuse two lines on
            end else begin
                pix <= '0;                    // blanking area
            end
        end
    end

endmodule

`default_nettype wire

/* hw/obj_pkg.sv */
`default_nettype none

package obj_pkg;

    // bus widths
    localparam int word_w = 16;   // frame table word
    localparam int rom_aw = 20;   // code + sub-line
    localparam int rom_dw = 64;   // 16 pixels of 4 bits

    // line timing and position offsets
    localparam logic [8:0] start_hpos = 9'h1d0;  // scan kicks off here
    localparam logic [9:0] x_bias     = 10'h40;
    localparam logic [9:0] y_bias     = 10'h10;

    // one frame table entry, x is the top word
    typedef struct packed {
        logic [word_w-1:0] x;     // 15:13 prio, 9:0 pos
        logic [word_w-1:0] y;     // 15 end, 14:13 bank, 9:0 pos
        logic [word_w-1:0] code;
        logic [word_w-1:0] attr;  // tile_m, tile_n, noscroll, vflip, hflip, pal
    } obj_entry_t;

    // command from scanner to draw engine
    typedef struct packed {
        logic [15:0] code;
        logic [3:0]  vsub;
        logic        hflip;
        logic [4:0]  pal;
        logic [8:0]  hpos;
        logic [2:0]  prio;
        logic [1:0]  bank;
    } obj_cmd_t;

    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] color;   // 0 is transparent
        logic [2:0] prio;
    } obj_pixel_t;

    typedef struct packed {
        logic [9:0] off_x;
        logic [9:0] off_y;
        logic       flip;
    } obj_cfg_t;

    typedef enum logic [1:0] {
        scan_idle,
        scan_read,    // entry on the bus, latch position
        scan_settle,  // tile match computing
        scan_check    // zone result ready, issue tiles
    } scan_state_e;

endpackage

`default_nettype wire

/* hw/obj_scan.sv */
`default_nettype none

module obj_scan #(
    parameter int table_aw = 8
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  obj_pkg::obj_cfg_t         cfg,
    input  wire logic [8:0]           vrender,   // one line ahead of display
    input  wire logic [8:0]           hdump,
    input  obj_pkg::obj_entry_t       entry,
    input  wire logic                 inzone,
    input  wire logic [3:0]           vsub,
    input  wire logic [15:0]          code_mn,
    input  wire logic                 dr_idle,
    output logic                      line,
    output logic [table_aw-1:0]       table_addr,
    output logic [8:0]                vrenderf,
    output logic [9:0]                obj_y,
    output logic [3:0]                n,         // column being issued
    output logic                      dr_start,
    output obj_pkg::obj_cmd_t         cmd
);

    obj_pkg::scan_state_e st;

    logic [table_aw-1:0] addr_q;
    logic [table_aw-1:0] addr_d;
    logic                start;
    logic                last_start;
    logic                new_line;
    logic [9:0]          obj_x;
    logic [9:0]          eff_x;
    logic [8:0]          hpos;
    logic [3:0]          npos;       // x offset of the tile, in tiles
    logic [3:0]          tile_n;
    logic                hflip;
    logic                table_end;
    logic                last_tile;
    logic                last_entry;
    logic                issue;
    logic                leave;

    assign start      = hdump == obj_pkg::start_hpos;
    assign new_line   = start && !last_start;    // rising match only
    assign tile_n     = entry.attr[11:8];
    assign hflip      = entry.attr[5];
    assign table_end  = entry.y[15] || (entry.attr[15:8] == 8'hff);
    assign last_tile  = n == tile_n;
    assign last_entry = &addr_q;
    assign eff_x      = obj_x + {2'b00, npos, 4'd0};
    assign hpos       = eff_x[8:0] - 9'd1;

    // check state with a tile ready and the draw engine free
    assign issue = (st == obj_pkg::scan_check) && inzone && dr_idle;
    // done with this entry, move the table on
    assign leave = (st == obj_pkg::scan_check) && (!inzone || (issue && last_tile));

    // address looks ahead so the entry is on the bus in scan_read
    always_comb begin
        if (new_line)
            addr_d = '0;
        else if (leave)
            addr_d = addr_q + 1'b1;
        else
            addr_d = addr_q;         // frozen while stalled in check
    end

    assign table_addr = addr_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= obj_pkg::scan_idle;
            addr_q     <= '0;
            line       <= 1'b0;
            last_start <= 1'b0;
            dr_start   <= 1'b0;
            n          <= 4'd0;
            npos       <= 4'd0;
        end else begin
            last_start <= start;
            addr_q     <= addr_d;
            dr_start   <= 1'b0;
            case (st)
                obj_pkg::scan_read: begin
                    if (table_end) begin
                        st <= obj_pkg::scan_idle;
                    end else begin
                        n    <= 4'd0;
                        npos <= hflip ? tile_n : 4'd0;   // flipped objects start right
                        st   <= obj_pkg::scan_settle;
                    end
                end
                obj_pkg::scan_settle: st <= obj_pkg::scan_check;
                obj_pkg::scan_check: begin
                    if (!inzone) begin
                        st <= last_entry ? obj_pkg::scan_idle : obj_pkg::scan_read;
                    end else if (dr_idle) begin
                        dr_start <= ~eff_x[9];   // off the left edge, drop it
                        if (last_tile) begin
                            st <= last_entry ? obj_pkg::scan_idle : obj_pkg::scan_read;
                        end else begin
                            n    <= n + 4'd1;
                            npos <= hflip ? npos - 4'd1 : npos + 4'd1;
                            st   <= obj_pkg::scan_settle;   // let tile match see n
                        end
                    end
                end
                default: ;   // idle until the next line
            endcase
            // line start wins over the case above, cuts off a late scan
            if (new_line) begin
                line <= ~line;
                st   <= obj_pkg::scan_read;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_line)
            vrenderf <= vrender ^ {1'b0, {8{cfg.flip}}};
        if (st == obj_pkg::scan_read) begin
            // bit 7 pins the object to the screen
            obj_x <= entry.x[9:0] + obj_pkg::x_bias - (entry.attr[7] ? 10'd0 : cfg.off_x);
            obj_y <= entry.y[9:0] + obj_pkg::y_bias - (entry.attr[7] ? 10'd0 : cfg.off_y);
        end
        if (issue) begin
            cmd <= '{code:  code_mn,
                     vsub:  vsub,
                     hflip: hflip,
                     pal:   entry.attr[4:0],
                     hpos:  hpos,
                     prio:  entry.x[15:13],
                     bank:  entry.y[14:13]};
        end
    end

endmodule

`default_nettype wire

/* hw/obj_table.sv */
`default_nettype none

module obj_table #(
    parameter int table_aw = 8
) (
    input  wire logic                 clk,
    input  wire logic                 tbl_we,
    input  wire logic [table_aw-1:0]  tbl_addr,
    input  obj_pkg::obj_entry_t       tbl_data,
    input  wire logic [table_aw-1:0]  rd_addr,
    output obj_pkg::obj_entry_t       rd_data
);

    // one entry per address, 64 bits wide
    obj_pkg::obj_entry_t mem [2**table_aw];

    // host side
    always_ff @(posedge clk) begin
        if (tbl_we)
            mem[tbl_addr] <= tbl_data;
    end

    // scanner side, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* hw/obj_tile_match.sv */
`default_nettype none

module obj_tile_match (
    input  wire logic           clk,
    input  obj_pkg::obj_entry_t entry,
    input  wire logic [8:0]     vrenderf,
    input  wire logic [9:0]     obj_y,
    input  wire logic [3:0]     n,         // tile column
    output logic                inzone,
    output logic [3:0]          vsub,
    output logic [15:0]         code_mn
);

    logic [9:0] ydiff;
    logic [3:0] tile_m;
    logic [3:0] m;       // tile row hit by this line
    logic [3:0] row;
    logic       vflip;

    assign tile_m = entry.attr[15:12];
    assign vflip  = entry.attr[6];
    assign ydiff  = {1'b0, vrenderf} - obj_y;    // wraps when above the object
    assign m      = ydiff[7:4];
    assign row    = vflip ? tile_m - m : m;      // count from the bottom

    always_ff @(posedge clk) begin
        // object is (tile_m+1)*16 lines tall
        inzone  <= (ydiff[9:8] == 2'b00) && (m <= tile_m);
        vsub    <= ydiff[3:0] ^ {4{vflip}};
        // next row of tiles sits 16 codes further on
        code_mn <= entry.code + {12'd0, n} + {8'd0, row, 4'd0};
    end

endmodule

`default_nettype wire

/* hw/obj_top.sv */
`default_nettype none

module obj_top #(
    parameter int table_aw = 8,
    parameter int line_w   = 512
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    // host writes
    input  wire logic                          cfg_we,
    input  wire logic [1:0]                    cfg_sel,
    input  wire logic [9:0]                    cfg_data,
    input  wire logic                          tbl_we,
    input  wire logic [table_aw-1:0]           tbl_addr,
    input  obj_pkg::obj_entry_t                tbl_data,
    // video timing
    input  wire logic [8:0]                    vrender,
    input  wire logic [8:0]                    hdump,
    // graphics rom
    input  wire logic                          rom_ok,
    input  wire logic [obj_pkg::rom_dw-1:0]    rom_data,
    output logic                               rom_cs,
    output logic [obj_pkg::rom_aw-1:0]         rom_addr,
    output obj_pkg::obj_pixel_t                pix
);

    obj_pkg::obj_cfg_t   cfg;
    obj_pkg::obj_entry_t entry;
    obj_pkg::obj_cmd_t   cmd;
    obj_pkg::obj_pixel_t buf_pix;

    logic [table_aw-1:0] table_addr;
    logic                line;
    logic [8:0]          vrenderf;
    logic [9:0]          obj_y;
    logic [3:0]          n;
    logic                inzone;
    logic [3:0]          vsub;
    logic [15:0]         code_mn;
    logic                dr_start;
    logic                dr_idle;
    logic                buf_we;
    logic [8:0]          buf_addr;

    obj_cfg_regs u_cfg (
        .clk      (clk),
        .rst      (rst),
        .cfg_we   (cfg_we),
        .cfg_sel  (cfg_sel),
        .cfg_data (cfg_data),
        .cfg      (cfg)
    );

    obj_table #(.table_aw(table_aw)) u_table (
        .clk      (clk),
        .tbl_we   (tbl_we),
        .tbl_addr (tbl_addr),
        .tbl_data (tbl_data),
        .rd_addr  (table_addr),
        .rd_data  (entry)
    );

    obj_tile_match u_match (
        .clk      (clk),
        .entry    (entry),
        .vrenderf (vrenderf),
        .obj_y    (obj_y),
        .n        (n),
        .inzone   (inzone),
        .vsub     (vsub),
        .code_mn  (code_mn)
    );

    obj_scan #(.table_aw(table_aw)) u_scan (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .vrender    (vrender),
        .hdump      (hdump),
        .entry      (entry),
        .inzone     (inzone),
        .vsub       (vsub),
        .code_mn    (code_mn),
        .dr_idle    (dr_idle),
        .line       (line),
        .table_addr (table_addr),
        .vrenderf   (vrenderf),
        .obj_y      (obj_y),
        .n          (n),
        .dr_start   (dr_start),
        .cmd        (cmd)
    );

    obj_draw #(.line_w(line_w)) u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .cmd      (cmd),
        .rom_ok   (rom_ok),
        .rom_data (rom_data),
        .dr_idle  (dr_idle),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_pix  (buf_pix)
    );

    obj_line_buf #(.line_w(line_w)) u_buf (
        .clk      (clk),
        .rst      (rst),
        .line     (line),
        .hdump    (hdump),
        .buf_we   (buf_we),
        .buf_addr (buf_addr),
        .buf_pix  (buf_pix),
        .pix      (pix)
    );

endmodule

`default_nettype wire
